// File: source/mfifo_params.svh
`ifndef MFIFO_PARAMS_SVH
`define MFIFO_PARAMS_SVH

// Sizing of the shared-storage multi-FIFO
// Everything else is derived from these three values in mfifo_pkg

// Number of logical FIFOs that share the storage
// Must be a power of two so the round-robin index wraps cleanly
`define MFIFO_NUM_FIFOS 4

// Number of entries in the shared data RAM
// The sender also starts with this many push credits after reset
`define MFIFO_DEPTH 16

// Payload width in bits
`define MFIFO_WIDTH 16

`endif

// File: source/mfifo_pkg.sv
`default_nettype none

`include "mfifo_params.svh"

package mfifo_pkg;

  // Sizes taken from the parameter macros
  localparam int numFifos = `MFIFO_NUM_FIFOS;
  localparam int numEntries = `MFIFO_DEPTH;
  localparam int dataBits = `MFIFO_WIDTH;

  // Derived widths, the count needs one extra bit to hold a full RAM
  localparam int fifoIdBits = $clog2(numFifos);
  localparam int addrBits = $clog2(numEntries);
  localparam int countBits = $clog2(numEntries + 1);

  typedef logic [fifoIdBits-1:0] fifoIdT;
  typedef logic [addrBits-1:0] addrT;
  typedef logic [countBits-1:0] countT;
  typedef logic [dataBits-1:0] dataT;

  // One push beat from the sender
  typedef struct packed {logic valid; fifoIdT fifoId; dataT data;} pushReqT;

  // Write into the data RAM
  typedef struct packed {logic valid; addrT addr; dataT data;} ramWrT;

  // Write into the pointer RAM, linking addr to the entry that follows it
  typedef struct packed {logic valid; addrT addr; addrT next;} ptrWrT;

  // Freshly written entry that becomes the tail of its FIFO
  typedef struct packed {logic valid; fifoIdT fifoId; addrT entry;} tailUpdT;

  // Entry handed back to the free list after its item was popped
  typedef struct packed {logic valid; addrT entry;} deallocT;

endpackage

`default_nettype wire

// File: source/syncRam.sv
`timescale 1ns/1ps
`default_nettype none

// Simple dual-port RAM, one write and one read per cycle
// Read data shows up one cycle after the address
module syncRam #(
  parameter int Words = 16,
  parameter int Bits = 16
) (
  input  logic                     clk,
  input  logic                     wrValid,
  input  logic [$clog2(Words)-1:0] wrAddr,
  input  logic [Bits-1:0]          wrData,
  input  logic [$clog2(Words)-1:0] rdAddr,
  output logic [Bits-1:0]          rdData
);

  // Storage array, contents are undefined until written
  logic [Bits-1:0] mem [Words];

  // Both ports use nonblocking updates on the same edge
  // so a read of an address being written returns the old word
  always_ff @(posedge clk) begin
    if (wrValid) begin
      mem[wrAddr] <= wrData;
    end
    rdData <= mem[rdAddr];
  end

endmodule

`default_nettype wire

// File: source/freeList.sv
`timescale 1ns/1ps
`default_nettype none

// Tracks which shared RAM entries are unused
// One bit per entry, a set bit means the entry is free
module freeList
  import mfifo_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  output logic    allocValid,
  output addrT    allocEntry,
  input  logic    allocTake,
  input  deallocT dealloc,
  output logic    full
);

  logic [numEntries-1:0] freeMap;
  logic [numEntries-1:0] freeMapNext;

  // Priority encoder for the lowest free entry
  // Scanning downward lets the last hit be the smallest index
  always_comb begin
    allocEntry = '0;
    for (int i = numEntries - 1; i >= 0; i--) begin
      if (freeMap[i]) begin
        allocEntry = addrT'(i);
      end
    end
  end

  assign allocValid = |freeMap;

  // No free entry left means every entry belongs to some FIFO
  assign full = ~allocValid;

  // A take clears the offered bit, a dealloc sets its bit again
  // The two never name the same entry since a freed entry was in use
  always_comb begin
    freeMapNext = freeMap;
    if (allocTake && allocValid) begin
      freeMapNext[allocEntry] = 1'b0;
    end
    if (dealloc.valid) begin
      freeMapNext[dealloc.entry] = 1'b1;
    end
  end

  // All entries start out free
  always_ff @(posedge clk) begin
    if (rst) begin
      freeMap <= '1;
    end else begin
      freeMap <= freeMapNext;
    end
  end

endmodule

`default_nettype wire

// File: source/pushCtrl.sv
`timescale 1ns/1ps
`default_nettype none

// Push side of the multi-FIFO
// Accepts one beat per cycle, stores it and returns credits for freed entries
module pushCtrl
  import mfifo_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  pushReqT push,
  input  logic    allocValid,
  input  addrT    allocEntry,
  output logic    allocTake,
  input  deallocT dealloc,
  output ramWrT   dataWr,
  output tailUpdT tailUpd,
  output logic    pushCredit
);

  logic   stageValid;
  fifoIdT stageFifo;
  addrT   stageEntry;
  dataT   stageData;
  logic   creditQ;

  // The credit rule guarantees a free entry whenever the sender is valid
  assign allocTake = push.valid && allocValid;

  // Control side of the stage, plus one cycle of credit delay
  always_ff @(posedge clk) begin
    if (rst) begin
      stageValid <= 1'b0;
      creditQ <= 1'b0;
    end else begin
      stageValid <= allocTake;
      creditQ <= dealloc.valid;
    end
  end

  // Beat and its entry are captured together
  always_ff @(posedge clk) begin
    if (allocTake) begin
      stageFifo <= push.fifoId;
      stageEntry <= allocEntry;
      stageData <= push.data;
    end
  end

  // Stage drives the RAM write and the tail link in the same cycle
  always_comb begin
    dataWr.valid = stageValid;
    dataWr.addr = stageEntry;
    dataWr.data = stageData;
    tailUpd.valid = stageValid;
    tailUpd.fifoId = stageFifo;
    tailUpd.entry = stageEntry;
  end

  // One credit per freed entry, one cycle after the dealloc
  assign pushCredit = creditQ;

endmodule

`default_nettype wire

// File: source/linkListMgr.sv
`timescale 1ns/1ps
`default_nettype none

// Keeps one singly linked list per logical FIFO
// Head, tail and the number of unclaimed entries live in registers,
// the next pointers live in the pointer RAM
module linkListMgr
  import mfifo_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  tailUpdT             tailUpd,
  input  logic [numFifos-1:0] headTake,
  output logic [numFifos-1:0] headValid,
  output addrT [numFifos-1:0] head,
  output logic [numFifos-1:0] ramEmpty,
  output ptrWrT               ptrWr,
  output addrT                ptrRdAddr,
  input  addrT                ptrRdData
);

  addrT  [numFifos-1:0] tail;
  countT [numFifos-1:0] count;
  logic  [numFifos-1:0] upd;
  logic  [numFifos-1:0] pending;
  logic                 pendValid;
  fifoIdT               pendFifo;
  fifoIdT               takeIdx;
  logic                 takeMore;

  // The pop side claims at most one head per cycle
  always_comb begin
    takeIdx = '0;
    for (int f = 0; f < numFifos; f++) begin
      if (headTake[f]) begin
        takeIdx = fifoIdT'(f);
      end
    end
  end

  // Entries remain behind the claimed head, so its next pointer is needed
  assign takeMore = |headTake && (count[takeIdx] > countT'(1));
  assign ptrRdAddr = head[takeIdx];

  always_comb begin
    for (int f = 0; f < numFifos; f++) begin
      upd[f] = tailUpd.valid && (tailUpd.fifoId == fifoIdT'(f));
      pending[f] = pendValid && (pendFifo == fifoIdT'(f));
      ramEmpty[f] = (count[f] == '0);
      // Head is unknown while its pointer read is still in flight
      headValid[f] = !ramEmpty[f] && !pending[f];
    end
  end

  // Appending to a list that has entries links the old tail to the new one
  always_comb begin
    ptrWr.valid = tailUpd.valid && (count[tailUpd.fifoId] != '0);
    ptrWr.addr = tail[tailUpd.fifoId];
    ptrWr.next = tailUpd.entry;
  end

  // Remember which FIFO waits for the pointer RAM
  always_ff @(posedge clk) begin
    if (rst) begin
      pendValid <= 1'b0;
    end else begin
      pendValid <= takeMore;
    end
  end

  always_ff @(posedge clk) begin
    pendFifo <= takeIdx;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head <= '0;
      tail <= '0;
      count <= '0;
    end else begin
      for (int f = 0; f < numFifos; f++) begin
        if (pending[f]) begin
          head[f] <= ptrRdData;
        end else if (upd[f] && (ramEmpty[f] || (count[f] == countT'(1) && headTake[f]))) begin
          // The new entry is the only one left, so it is the head right away
          head[f] <= tailUpd.entry;
        end
        if (upd[f]) begin
          tail[f] <= tailUpd.entry;
        end
        // A push and a claim in the same cycle leave the count unchanged
        if (upd[f] && !headTake[f]) begin
          count[f] <= count[f] + countT'(1);
        end else if (headTake[f] && !upd[f]) begin
          count[f] <= count[f] - countT'(1);
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: source/popCtrl.sv
`timescale 1ns/1ps
`default_nettype none

// Pop side of the multi-FIFO
// Every FIFO has a one-entry staging slot, and all slots share the single
// data RAM read port through a round-robin arbiter
module popCtrl
  import mfifo_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [numFifos-1:0] headValid,
  input  addrT [numFifos-1:0] head,
  input  logic [numFifos-1:0] ramEmpty,
  output logic [numFifos-1:0] headTake,
  output addrT                dataRdAddr,
  input  dataT                dataRdData,
  output logic [numFifos-1:0] popValid,
  input  logic [numFifos-1:0] popReady,
  output dataT [numFifos-1:0] popData,
  output logic [numFifos-1:0] popEmpty,
  output deallocT             dealloc
);

  logic [numFifos-1:0] slotValid;
  dataT [numFifos-1:0] slotData;
  addrT [numFifos-1:0] slotEntry;
  logic [numFifos-1:0] freePend;
  addrT [numFifos-1:0] freeEntry;
  logic [numFifos-1:0] inFlight;
  logic [numFifos-1:0] pop;
  logic [numFifos-1:0] readReq;
  logic                rdValid;
  fifoIdT              rdFifo;
  addrT                rdEntry;
  fifoIdT              grantIdx;
  fifoIdT              grantLast;
  fifoIdT              freeIdx;
  fifoIdT              freeLast;

  // First requester after the last winner, returns last when nobody asks
  function automatic fifoIdT rrPick(input logic [numFifos-1:0] req, input fifoIdT last);
    fifoIdT cand;
    fifoIdT pick;
    pick = last;
    for (int i = numFifos; i >= 1; i--) begin
      cand = fifoIdT'(int'(last) + i);
      if (req[cand]) begin
        pick = cand;
      end
    end
    return pick;
  endfunction

  always_comb begin
    for (int f = 0; f < numFifos; f++) begin
      inFlight[f] = rdValid && (rdFifo == fifoIdT'(f));
      // A slot waits until its previous entry has gone back to the free list
      popValid[f] = slotValid[f] && !freePend[f];
      pop[f] = popValid[f] && popReady[f];
      popEmpty[f] = !slotValid[f] && !inFlight[f] && ramEmpty[f];
      // Slot must be free by the time the read data arrives
      readReq[f] = headValid[f] && !inFlight[f] && (!slotValid[f] || pop[f]);
    end
  end

  assign grantIdx = rrPick(readReq, grantLast);
  assign freeIdx = rrPick(freePend, freeLast);
  assign dataRdAddr = head[grantIdx];
  assign popData = slotData;

  always_comb begin
    headTake = '0;
    if (|readReq) begin
      headTake[grantIdx] = 1'b1;
    end
  end

  // Only one freed entry per cycle goes back, pops from several FIFOs queue up here
  assign dealloc.valid = |freePend;
  assign dealloc.entry = freeEntry[freeIdx];

  always_ff @(posedge clk) begin
    if (rst) begin
      slotValid <= '0;
      freePend <= '0;
      rdValid <= 1'b0;
      grantLast <= '0;
      freeLast <= '0;
    end else begin
      rdValid <= |readReq;
      if (|readReq) begin
        grantLast <= grantIdx;
      end
      if (|freePend) begin
        freeLast <= freeIdx;
        freePend[freeIdx] <= 1'b0;
      end
      for (int f = 0; f < numFifos; f++) begin
        if (pop[f]) begin
          slotValid[f] <= 1'b0;
          freePend[f] <= 1'b1;
        end
        if (inFlight[f]) begin
          slotValid[f] <= 1'b1;
        end
      end
    end
  end

  // Read data lands in the slot of the FIFO granted one cycle earlier
  always_ff @(posedge clk) begin
    rdFifo <= grantIdx;
    rdEntry <= dataRdAddr;
    for (int f = 0; f < numFifos; f++) begin
      if (pop[f]) begin
        freeEntry[f] <= slotEntry[f];
      end
      if (inFlight[f]) begin
        slotData[f] <= dataRdData;
        slotEntry[f] <= rdEntry;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/mfifoTop.sv
`timescale 1ns/1ps
`default_nettype none

// Shared-storage multi-FIFO with a valid/credit push port and
// one ready/valid pop port per logical FIFO
module mfifoTop
  import mfifo_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  pushReqT             push,
  output logic                pushCredit,
  output logic                pushFull,
  output logic [numFifos-1:0] popValid,
  input  logic [numFifos-1:0] popReady,
  output dataT [numFifos-1:0] popData,
  output logic [numFifos-1:0] popEmpty
);

  logic                allocValid;
  addrT                allocEntry;
  logic                allocTake;
  deallocT             dealloc;
  ramWrT               dataWr;
  tailUpdT             tailUpd;
  ptrWrT               ptrWr;
  addrT                ptrRdAddr;
  addrT                ptrRdData;
  logic [numFifos-1:0] headValid;
  addrT [numFifos-1:0] head;
  logic [numFifos-1:0] headTake;
  logic [numFifos-1:0] ramEmpty;
  addrT                dataRdAddr;
  dataT                dataRdData;

  freeList uFreeList (
    .clk,
    .rst,
    .allocValid,
    .allocEntry,
    .allocTake,
    .dealloc,
    .full(pushFull)
  );

  pushCtrl uPushCtrl (
    .clk,
    .rst,
    .push,
    .allocValid,
    .allocEntry,
    .allocTake,
    .dealloc,
    .dataWr,
    .tailUpd,
    .pushCredit
  );

  linkListMgr uLinkListMgr (
    .clk,
    .rst,
    .tailUpd,
    .headTake,
    .headValid,
    .head,
    .ramEmpty,
    .ptrWr,
    .ptrRdAddr,
    .ptrRdData
  );

  popCtrl uPopCtrl (
    .clk,
    .rst,
    .headValid,
    .head,
    .ramEmpty,
    .headTake,
    .dataRdAddr,
    .dataRdData,
    .popValid,
    .popReady,
    .popData,
    .popEmpty,
    .dealloc
  );

  // Payload storage shared by all FIFOs
  syncRam #(
    .Words(numEntries),
    .Bits(dataBits)
  ) dataRam (
    .clk,
    .wrValid(dataWr.valid),
    .wrAddr(dataWr.addr),
    .wrData(dataWr.data),
    .rdAddr(dataRdAddr),
    .rdData(dataRdData)
  );

  // Next pointers of the linked lists, indexed by entry
  syncRam #(
    .Words(numEntries),
    .Bits(addrBits)
  ) ptrRam (
    .clk,
    .wrValid(ptrWr.valid),
    .wrAddr(ptrWr.addr),
    .wrData(ptrWr.next),
    .rdAddr(ptrRdAddr),
    .rdData(ptrRdData)
  );

endmodule

`default_nettype wire

// File: sim/mfifo_chk.sv
`timescale 1ns/1ps
`default_nettype none

// Protocol checks on the multi-FIFO ports, bound into mfifoTop
module mfifoChk
  import mfifo_pkg::*;
(
  input logic                clk,
  input logic                rst,
  input logic                pushCredit,
  input logic [numFifos-1:0] popValid,
  input logic [numFifos-1:0] popReady,
  input dataT [numFifos-1:0] popData,
  input logic [numFifos-1:0] popEmpty
);

  int popCount;
  int creditCount;

  // Running totals of completed pop handshakes and returned credits
  always_ff @(posedge clk) begin
    if (rst) begin
      popCount <= 0;
      creditCount <= 0;
    end else begin
      popCount <= popCount + $countones(popValid & popReady);
      creditCount <= creditCount + (pushCredit ? 1 : 0);
    end
  end

  // Every credit pays back an item that already left through a pop port
  // Returned credits therefore never run ahead of the pops
  creditFollowsPop: assert property (
    @(posedge clk) disable iff (rst) creditCount + (pushCredit ? 1 : 0) <= popCount
  ) else $error("pushCredit returned more credits than items were popped");

  for (genvar f = 0; f < numFifos; f++) begin : gPort
    // A stalled pop port keeps its item in place until it is taken
    popHold: assert property (
      @(posedge clk) disable iff (rst)
      popValid[f] && !popReady[f] |=> popValid[f] && $stable(popData[f])
    ) else $error("Pop port %0d changed while it was stalled", f);

    // An empty port needs a head claim and a RAM read before it can offer an item
    validNotEmpty: assert property (
      @(posedge clk) disable iff (rst)
      popEmpty[f] |-> !popValid[f] ##1 !popValid[f] ##1 !popValid[f]
    ) else $error("Pop port %0d offered an item too soon after being empty", f);
  end

endmodule

bind mfifoTop mfifoChk uChk (
  .clk,
  .rst,
  .pushCredit,
  .popValid,
  .popReady,
  .popData,
  .popEmpty
);

`default_nettype wire

// File: sim/mfifoTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mfifo_params.svh"

// Table-driven testbench with one reference queue per FIFO and a credit tracker
module mfifoTb
  import mfifo_pkg::*;
();

  typedef logic [numFifos-1:0] maskT;

  // One phase of stimulus, the FIFO of push i sits in fifoSel[2*i +: 2]
  typedef struct packed {
    logic [1:0]  kind;
    logic [4:0]  numPush;
    logic [31:0] fifoSel;
    dataT        dataBase;
    maskT        ready;
  } phaseT;

  localparam int numPhases = 4;
  localparam int waitLimit = 400;
  localparam int randomCycles = 300;
  localparam logic [1:0] kindOrder = 2'd0;
  localparam logic [1:0] kindCapacity = 2'd1;
  localparam logic [1:0] kindHold = 2'd2;
  localparam logic [1:0] kindRandom = 2'd3;
  localparam int condFull = 0;
  localparam int condNotFull = 1;
  localparam int condValid = 2;
  localparam int condOnlyHeld = 3;
  localparam int condSettled = 4;
  localparam int condDrained = 5;

  logic    clk;
  logic    rst;
  pushReqT push;
  logic    pushCredit;
  logic    pushFull;
  maskT    popValid;
  maskT    popReady;
  maskT    popEmpty;
  dataT [numFifos-1:0] popData;

  phaseT stim[numPhases];
  string phaseName[numPhases];
  dataT  refQ[numFifos][$];
  logic  heldValid[numFifos];
  string curTest;
  int    credits;
  int    creditsRx;
  int    popsDone;
  int    testErrors;
  int    totalErrors;
  int    passCount;
  int    failCount;
  int    seed;
  logic  timedOut;

  mfifoTop i_dut (
    .clk,
    .rst,
    .push,
    .pushCredit,
    .pushFull,
    .popValid,
    .popReady,
    .popData,
    .popEmpty
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic checkEq(input string what, input int expected, input int actual);
    assert (expected == actual) else begin
      $display("Error %s: %s expected %0h actual %0h", curTest, what, expected, actual);
      testErrors++;
    end
  endtask

  // Items pushed but not yet popped, over all FIFOs
  function automatic int pendingItems();
    int n;
    n = 0;
    for (int f = 0; f < numFifos; f++) begin
      n += refQ[f].size();
    end
    return n;
  endfunction

  // A FIFO is empty exactly when its reference queue is
  function automatic maskT emptyMask();
    maskT m;
    for (int f = 0; f < numFifos; f++) begin
      m[f] = (refQ[f].size() == 0);
    end
    return m;
  endfunction

  function automatic logic condMet(input int what, input int fifo);
    case (what)
      condFull: return pushFull;
      condNotFull: return !pushFull;
      condValid: return popValid[fifo];
      condOnlyHeld: return pendingItems() == refQ[fifo].size();
      condSettled: return credits == `MFIFO_DEPTH - pendingItems();
      default: return credits == `MFIFO_DEPTH && pendingItems() == 0;
    endcase
  endfunction

  // One cycle seen from the falling edge, where all DUT outputs are settled
  // The ready mask and push driven here are taken at the next rising edge
  task automatic cycleStep(input logic wantPush, input fifoIdT fifo, input dataT data,
                           input maskT ready, output logic pushed);
    @(negedge clk);
    if (pushCredit) begin
      credits++;
      creditsRx++;
    end
    assert (creditsRx <= popsDone) else begin
      $display("Test %s received a credit before any item was popped for it", curTest);
      testErrors++;
    end
    for (int f = 0; f < numFifos; f++) begin
      // A stalled port keeps offering the oldest item of its FIFO
      if (heldValid[f] && popValid[f] && refQ[f].size() != 0) begin
        checkEq($sformatf("held popData[%0d]", f), int'(refQ[f][0]), int'(popData[f]));
      end
      if (popValid[f] && ready[f]) begin
        assert (refQ[f].size() != 0) else begin
          $display("Test %s saw FIFO %0d pop an item that was never pushed", curTest, f);
          testErrors++;
        end
        if (refQ[f].size() != 0) begin
          checkEq($sformatf("popData[%0d]", f), int'(refQ[f].pop_front()), int'(popData[f]));
        end
        popsDone++;
      end
      heldValid[f] = popValid[f] && !ready[f];
    end
    popReady = ready;
    // The sender may only drive a beat while it holds a credit
    pushed = wantPush && (credits > 0);
    push.valid = pushed;
    push.fifoId = fifo;
    push.data = data;
    if (pushed) begin
      credits--;
      refQ[fifo].push_back(data);
    end
    assert (credits >= 0 && credits <= `MFIFO_DEPTH) else begin
      $display("Test %s pushed the credit counter out of range to %0d", curTest, credits);
      testErrors++;
    end
  endtask

  task automatic idle(input maskT ready);
    logic pushed;
    cycleStep(1'b0, '0, '0, ready, pushed);
  endtask

  task automatic pushItem(input fifoIdT fifo, input dataT data, input maskT ready);
    logic pushed;
    int n;
    pushed = 1'b0;
    n = 0;
    while (!pushed && !timedOut) begin
      cycleStep(1'b1, fifo, data, ready, pushed);
      n++;
      if (!pushed && n >= waitLimit) begin
        $display("Test %s timed out waiting for a push credit", curTest);
        timedOut = 1'b1;
      end
    end
  endtask

  task automatic waitFor(input int what, input maskT ready, input int fifo, input string label);
    int n;
    n = 0;
    while (!timedOut && !condMet(what, fifo)) begin
      idle(ready);
      n++;
      if (n >= waitLimit) begin
        $display("Test %s timed out waiting for %s", curTest, label);
        timedOut = 1'b1;
      end
    end
  endtask

  // Empties every FIFO and expects all credits back, one per pop
  task automatic drainCheck();
    waitFor(condDrained, '1, 0, "the FIFOs to drain");
    checkEq("pushFull after drain", 0, int'(pushFull));
    checkEq("popEmpty after drain", int'(emptyMask()), int'(popEmpty));
  endtask

  task automatic finishTest();
    if (testErrors == 0 && !timedOut) begin
      $display("Test %s passed", curTest);
      passCount++;
    end else begin
      $display("Test %s failed with %0d errors", curTest, testErrors);
      failCount++;
    end
    totalErrors += testErrors;
  endtask

  task automatic runPhase(input int p);
    phaseT  row;
    fifoIdT fifo;
    dataT   data;
    maskT   ready;
    logic   doPush;
    logic   pushed;
    row = stim[p];
    curTest = phaseName[p];
    testErrors = 0;
    if (row.kind == kindRandom) begin
      for (int i = 0; i < randomCycles; i++) begin
        doPush = 1'($random(seed));
        fifo = fifoIdT'($random(seed));
        data = dataT'($random(seed));
        ready = maskT'($random(seed));
        cycleStep(doPush, fifo, data, ready, pushed);
      end
    end else begin
      for (int i = 0; i < int'(row.numPush); i++) begin
        pushItem(row.fifoSel[fifoIdBits*i +: fifoIdBits], row.dataBase + dataT'(i), row.ready);
      end
    end
    fifo = row.fifoSel[fifoIdBits-1:0];
    if (row.kind == kindCapacity) begin
      waitFor(condFull, row.ready, fifo, "pushFull");
      checkEq("popEmpty with one FIFO full", int'(emptyMask()), int'(popEmpty));
      waitFor(condValid, row.ready, fifo, "popValid");
      // A single pop frees one entry and pushFull has to drop
      idle(row.ready | (maskT'(1) << fifo));
      waitFor(condNotFull, row.ready, fifo, "pushFull to drop");
    end else if (row.kind == kindHold) begin
      waitFor(condOnlyHeld, row.ready, fifo, "the ready FIFOs to empty");
      waitFor(condSettled, row.ready, fifo, "credits of the popped items");
      // Observation window in which the stalled FIFO must not return credits
      repeat (8) idle(row.ready);
      checkEq("credits with one FIFO held", `MFIFO_DEPTH - pendingItems(), credits);
      checkEq("popValid of the held FIFO", 1, int'(popValid[fifo]));
      checkEq("popData of the held FIFO", int'(refQ[fifo][0]), int'(popData[fifo]));
    end
    drainCheck();
    finishTest();
  endtask

  initial begin
    rst = 1'b1;
    push = '0;
    popReady = '0;
    seed = 32'hb53bbeb7;
    credits = `MFIFO_DEPTH;
    creditsRx = 0;
    popsDone = 0;
    totalErrors = 0;
    passCount = 0;
    failCount = 0;
    timedOut = 1'b0;
    for (int f = 0; f < numFifos; f++) begin
      heldValid[f] = 1'b0;
    end
    // Interleaved pushes while FIFOs 0 and 3 pile up
    stim[0] = '{kindOrder, 5'd16, 32'h1BE4_1BE4, 16'h1000, 4'b0110};
    phaseName[0] = "order";
    stim[1] = '{kindCapacity, 5'(`MFIFO_DEPTH), 32'h0, 16'h2000, 4'b0000};
    phaseName[1] = "capacity";
    // FIFO 1 is held while FIFO 2 drains
    stim[2] = '{kindHold, 5'd8, 32'h0000_9999, 16'h3000, 4'b0100};
    phaseName[2] = "backpressure";
    stim[3] = '{kindRandom, 5'd0, 32'h0, 16'h0, 4'b0000};
    phaseName[3] = "random";

    curTest = "reset";
    testErrors = 0;
    repeat (4) @(negedge clk);
    checkEq("pushCredit in reset", 0, int'(pushCredit));
    checkEq("popValid in reset", 0, int'(popValid));
    checkEq("popEmpty in reset", int'(maskT'('1)), int'(popEmpty));
    checkEq("pushFull in reset", 0, int'(pushFull));
    rst = 1'b0;
    repeat (5) idle('1);
    checkEq("credits before the first pop", 0, creditsRx);
    checkEq("popValid after reset", 0, int'(popValid));
    checkEq("popEmpty after reset", int'(emptyMask()), int'(popEmpty));
    finishTest();

    for (int p = 0; p < numPhases; p++) begin
      if (!timedOut) begin
        runPhase(p);
      end
    end

    $display("Tests passed %0d, failed %0d, errors %0d", passCount, failCount, totalErrors);
    if (failCount == 0 && !timedOut) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+source
source/mfifo_pkg.sv
source/syncRam.sv
source/freeList.sv
source/pushCtrl.sv
source/linkListMgr.sv
source/popCtrl.sv
source/mfifoTop.sv
sim/mfifo_chk.sv
sim/mfifoTb.sv

// File: Makefile
# Verilator build and run of the multi-FIFO testbench

VERILATOR ?= verilator
TOP ?= mfifoTb
FILELIST ?= all.f
OBJDIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
